//--- compile.f
+incdir+testbench
design/mipsMemPkg.sv
design/storeAligner.sv
design/loadAligner.sv
design/excPrioritizer.sv
design/cp0Regs.sv
design/memWbReg.sv
design/memStage.sv
testbench/memStageTb.sv

//--- design/cp0Regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Regs #(
    parameter mipsMemPkg::word_t excEntry = 32'hBFC0_0380
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  mipsMemPkg::excCode_t excCode,
    input  logic                 inDelaySlot,
    input  mipsMemPkg::word_t    pc,
    input  mipsMemPkg::word_t    badVAddr,
    input  logic [5:0]           extInt,
    input  logic                 writeEn,
    input  mipsMemPkg::regAddr_t writeAddr,
    input  mipsMemPkg::word_t    writeData,
    input  mipsMemPkg::regAddr_t readAddr,
    output mipsMemPkg::word_t    readData,
    output mipsMemPkg::word_t    status,
    output mipsMemPkg::word_t    cause,
    output logic                 redirectValid,
    output mipsMemPkg::word_t    redirectPc
);
    import mipsMemPkg::*;

    word_t statusQ;
    word_t causeQ;
    word_t epcQ;
    word_t badVAddrQ;

    logic isEret;
    logic isRealExc;
    logic isAddrExc;

    assign isEret    = (excCode == excEret);
    assign isRealExc = (excCode != excNone) && !isEret;
    assign isAddrExc = (excCode == excAdel) || (excCode == excAdes);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            statusQ   <= '0;
            causeQ    <= '0;
            epcQ      <= '0;
            badVAddrQ <= '0;
        end else if (!stall) begin
            causeQ[15:10] <= extInt;  // pending hw interrupt lines
            if (isRealExc) begin
                statusQ[1]  <= 1'b1;  // EXL
                causeQ[6:2] <= excCode;
                causeQ[31]  <= inDelaySlot;  // BD
                // restart at the branch when trapping in its delay slot
                epcQ        <= inDelaySlot ? pc - 32'd4 : pc;
                if (isAddrExc) begin
                    badVAddrQ <= badVAddr;
                end
            end else if (isEret) begin
                statusQ[1] <= 1'b0;
            end else if (writeEn) begin
                case (writeAddr)
                    cp0Status: statusQ     <= writeData;
                    cp0Cause:  causeQ[9:8] <= writeData[9:8];  // soft int bits only
                    cp0Epc:    epcQ        <= writeData;
                    default:   ;  // BadVAddr is read only
                endcase
            end
        end
    end

    // mfc0 read port
    always_comb begin
        case (readAddr)
            cp0Status:   readData = statusQ;
            cp0Cause:    readData = causeQ;
            cp0Epc:      readData = epcQ;
            cp0BadVAddr: readData = badVAddrQ;
            default:     readData = '0;
        endcase
    end

    assign status = statusQ;
    assign cause  = causeQ;

    assign redirectValid = (excCode != excNone);
    assign redirectPc    = isEret ? epcQ : excEntry;

endmodule

`default_nettype wire

//--- design/excPrioritizer.sv
`timescale 1ns/1ps
`default_nettype none

module excPrioritizer (
    input  logic                  valid,
    input  mipsMemPkg::excFlags_t flags,
    input  mipsMemPkg::word_t     pc,
    input  mipsMemPkg::word_t     addr,
    input  logic                  addrErrorL,
    input  logic                  addrErrorS,
    input  mipsMemPkg::word_t     status,
    input  mipsMemPkg::word_t     cause,
    input  logic [5:0]            extInt,
    output mipsMemPkg::excCode_t  excCode,
    output logic                  isExc,
    output mipsMemPkg::word_t     badVAddr
);
    import mipsMemPkg::*;

    logic pcError;
    logic softInt;
    logic hardInt;
    logic intPending;

    assign pcError = |pc[1:0];  // fetch from a misaligned pc

    assign softInt = |(status[9:8] & cause[9:8]);
    assign hardInt = |(status[15:10] & extInt);

    // IE set and not already in exception level
    assign intPending = status[0] & ~status[1] & (softInt | hardInt);

    always_comb begin
        if (!valid) begin
            excCode = excNone;  // bubble cannot trap
        end else if (intPending) begin
            excCode = excInt;
        end else if (addrErrorL || pcError) begin
            excCode = excAdel;
        end else if (addrErrorS) begin
            excCode = excAdes;
        end else if (flags.syscall) begin
            excCode = excSys;
        end else if (flags.brk) begin
            excCode = excBp;
        end else if (flags.ri) begin
            excCode = excRi;
        end else if (flags.overflow) begin
            excCode = excOv;
        end else if (flags.eret) begin
            excCode = excEret;
        end else begin
            excCode = excNone;
        end
    end

    // eret also counts, it flushes and redirects like a trap
    assign isExc = (excCode != excNone);

    assign badVAddr = pcError ? pc : addr;

endmodule

`default_nettype wire

//--- design/loadAligner.sv
`timescale 1ns/1ps
`default_nettype none

module loadAligner (
    input  mipsMemPkg::opcode_t op,
    input  mipsMemPkg::word_t   addr,
    input  mipsMemPkg::word_t   readData,
    output mipsMemPkg::word_t   loadData,
    output logic                isLoad,
    output logic                addrErrorL
);
    import mipsMemPkg::*;

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // pick the addressed lane out of the word
    always_comb begin
        case (addr[1:0])
            2'b00:   byteSel = readData[7:0];
            2'b01:   byteSel = readData[15:8];
            2'b10:   byteSel = readData[23:16];
            default: byteSel = readData[31:24];
        endcase
    end

    assign halfSel = addr[1] ? readData[31:16] : readData[15:0];

    always_comb begin
        loadData   = '0;
        isLoad     = 1'b1;
        addrErrorL = 1'b0;
        case (op)
            opLw: begin
                loadData   = readData;
                addrErrorL = |addr[1:0];
            end
            opLh: begin
                loadData   = {{16{halfSel[15]}}, halfSel};
                addrErrorL = addr[0];
            end
            opLhu: begin
                loadData   = {16'h0000, halfSel};
                addrErrorL = addr[0];
            end
            opLb: begin
                loadData = {{24{byteSel[7]}}, byteSel};  // byte loads never misalign
            end
            opLbu: begin
                loadData = {24'h00_0000, byteSel};
            end
            default: begin
                isLoad = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage #(
    parameter mipsMemPkg::word_t excEntry = 32'hBFC0_0380
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic [5:0]           extInt,
    input  mipsMemPkg::memReq_t  req,
    input  mipsMemPkg::word_t    readData,
    output mipsMemPkg::byteEn_t  byteEnable,
    output mipsMemPkg::word_t    writeData,
    output logic                 memEn,
    output logic                 isExc,
    output mipsMemPkg::excCode_t excCode,
    output logic                 redirectValid,
    output mipsMemPkg::word_t    redirectPc,
    output mipsMemPkg::wbData_t  wb
);
    import mipsMemPkg::*;

    word_t loadData;
    word_t status;
    word_t cause;
    word_t badVAddr;
    word_t cp0ReadData;
    word_t wbResult;
    logic  isLoad;
    logic  addrErrorL;
    logic  addrErrorS;
    logic  cp0WriteEn;

    storeAligner i_storeAligner (
        .op(req.op), .addr(req.addr), .storeData(req.storeData), .isExc(isExc),
        .byteEnable(byteEnable), .writeData(writeData), .addrErrorS(addrErrorS)
    );

    loadAligner i_loadAligner (
        .op(req.op), .addr(req.addr), .readData(readData),
        .loadData(loadData), .isLoad(isLoad), .addrErrorL(addrErrorL)
    );

    excPrioritizer i_excPrioritizer (
        .valid(req.valid), .flags(req.excFlags), .pc(req.pc), .addr(req.addr),
        .addrErrorL(addrErrorL), .addrErrorS(addrErrorS),
        .status(status), .cause(cause), .extInt(extInt),
        .excCode(excCode), .isExc(isExc), .badVAddr(badVAddr)
    );

    // mtc0 only lands when the instruction itself does not trap
    assign cp0WriteEn = req.valid & req.mtc0 & ~isExc;

    cp0Regs #(.excEntry(excEntry)) i_cp0Regs (
        .clk(clk), .arstN(arstN), .stall(stall),
        .excCode(excCode), .inDelaySlot(req.excFlags.inDelaySlot),
        .pc(req.pc), .badVAddr(badVAddr), .extInt(extInt),
        .writeEn(cp0WriteEn), .writeAddr(req.cp0Addr), .writeData(req.aluResult),
        .readAddr(req.cp0Addr), .readData(cp0ReadData),
        .status(status), .cause(cause),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    // writeback source select
    assign wbResult = req.mfc0     ? cp0ReadData :
                      req.memToReg ? loadData    : req.aluResult;

    // stores show up as a nonzero lane mask
    assign memEn = req.valid & ~isExc & (isLoad | (|byteEnable));

    memWbReg i_memWbReg (
        .clk(clk), .arstN(arstN), .stall(stall), .isExc(isExc),
        .regWrite(req.valid & req.regWrite), .wreg(req.wreg), .data(wbResult),
        .wb(wb)
    );

endmodule

`default_nettype wire

//--- design/memWbReg.sv
`timescale 1ns/1ps
`default_nettype none

module memWbReg (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 isExc,
    input  logic                 regWrite,   // already qualified by valid
    input  mipsMemPkg::regAddr_t wreg,
    input  mipsMemPkg::word_t    data,
    output mipsMemPkg::wbData_t  wb
);
    import mipsMemPkg::*;

    logic     regWriteQ;
    regAddr_t wregQ;
    word_t    dataQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteQ <= 1'b0;
        end else if (!stall) begin
            regWriteQ <= regWrite & ~isExc;  // trapping instr never writes back
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wregQ <= wreg;
            dataQ <= data;
        end
    end

    assign wb.regWrite = regWriteQ;
    assign wb.wreg     = wregQ;
    assign wb.data     = dataQ;

endmodule

`default_nettype wire

//--- design/mipsMemPkg.sv
`default_nettype none

package mipsMemPkg;

    typedef logic [31:0] word_t;     // data word or address
    typedef logic [3:0]  byteEn_t;   // one bit per byte lane
    typedef logic [4:0]  regAddr_t;  // gpr or cp0 register number
    typedef logic [5:0]  opcode_t;   // primary opcode field

    // load opcodes
    localparam opcode_t opLb  = 6'h20;
    localparam opcode_t opLh  = 6'h21;
    localparam opcode_t opLw  = 6'h23;
    localparam opcode_t opLbu = 6'h24;
    localparam opcode_t opLhu = 6'h25;

    // store opcodes
    localparam opcode_t opSb  = 6'h28;
    localparam opcode_t opSh  = 6'h29;
    localparam opcode_t opSw  = 6'h2B;

    // Cause.ExcCode values, the last two never reach the register
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdel = 5'd4,
        excAdes = 5'd5,
        excSys  = 5'd8,
        excBp   = 5'd9,
        excRi   = 5'd10,
        excOv   = 5'd12,
        excEret = 5'd30,
        excNone = 5'd31
    } excCode_t;

    // cp0 register numbers
    localparam regAddr_t cp0BadVAddr = 5'd8;
    localparam regAddr_t cp0Status   = 5'd12;
    localparam regAddr_t cp0Cause    = 5'd13;
    localparam regAddr_t cp0Epc      = 5'd14;

    // flags raised in decode and execute
    typedef struct packed {
        logic syscall;
        logic brk;
        logic eret;
        logic ri;
        logic overflow;
        logic inDelaySlot;
    } excFlags_t;

    // one instruction in the memory stage
    typedef struct packed {
        logic      valid;
        opcode_t   op;
        word_t     addr;        // effective address from the alu
        word_t     storeData;
        word_t     pc;
        word_t     aluResult;   // also carries the mtc0 source value
        regAddr_t  wreg;
        logic      regWrite;
        logic      memToReg;
        logic      mtc0;
        logic      mfc0;
        regAddr_t  cp0Addr;
        excFlags_t excFlags;
    } memReq_t;

    typedef struct packed {
        logic     regWrite;
        regAddr_t wreg;
        word_t    data;
    } wbData_t;

endpackage

`default_nettype wire

//--- design/storeAligner.sv
`timescale 1ns/1ps
`default_nettype none

module storeAligner (
    input  mipsMemPkg::opcode_t op,
    input  mipsMemPkg::word_t   addr,
    input  mipsMemPkg::word_t   storeData,
    input  logic                isExc,
    output mipsMemPkg::byteEn_t byteEnable,
    output mipsMemPkg::word_t   writeData,
    output logic                addrErrorS
);
    import mipsMemPkg::*;

    byteEn_t laneEn;  // enables before exception gating

    always_comb begin
        laneEn     = '0;
        writeData  = '0;
        addrErrorS = 1'b0;
        case (op)
            opSw: begin
                laneEn     = 4'b1111;
                writeData  = storeData;
                addrErrorS = |addr[1:0];
            end
            opSh: begin
                laneEn     = addr[1] ? 4'b1100 : 4'b0011;  // upper or lower half
                writeData  = {2{storeData[15:0]}};
                addrErrorS = addr[0];
            end
            opSb: begin
                laneEn    = byteEn_t'(4'b0001 << addr[1:0]);
                writeData = {4{storeData[7:0]}};  // same byte on every lane
            end
            default: begin
                laneEn = '0;  // not a store
            end
        endcase
    end

    // no write may reach memory once the instruction traps
    assign byteEnable = isExc ? byteEn_t'(0) : laneEn;

endmodule

`default_nettype wire

//--- testbench/memStageVectors.svh
`ifndef MEM_STAGE_VECTORS_SVH
`define MEM_STAGE_VECTORS_SVH

// op, addr (cp0 number for mtc0/mfc0), data, pc, ctl, byteEnable, writeData,
// excCode, eret target, next-cycle wb.regWrite, next-cycle wb.data
// ctl: [15:10] extInt, [8] stall, [7] mfc0, [6] mtc0, [5:0] excFlags_t bits

// stores, byte and half-word lanes replicated
addVector(opSb, 'h100, 'hA1B2C3D4, 'h400, 'h000, 4'h1, 'hD4D4D4D4, excNone, 'h0, 1'b0, 'h0);
addVector(opSb, 'h101, 'hA1B2C3D4, 'h400, 'h000, 4'h2, 'hD4D4D4D4, excNone, 'h0, 1'b0, 'h0);
addVector(opSb, 'h102, 'hA1B2C3D4, 'h400, 'h000, 4'h4, 'hD4D4D4D4, excNone, 'h0, 1'b0, 'h0);
addVector(opSb, 'h103, 'hA1B2C3D4, 'h400, 'h000, 4'h8, 'hD4D4D4D4, excNone, 'h0, 1'b0, 'h0);
addVector(opSh, 'h200, 'hA1B2C3D4, 'h400, 'h000, 4'h3, 'hC3D4C3D4, excNone, 'h0, 1'b0, 'h0);
addVector(opSh, 'h202, 'hA1B2C3D4, 'h400, 'h000, 4'hC, 'hC3D4C3D4, excNone, 'h0, 1'b0, 'h0);
addVector(opSw, 'h300, 'hA1B2C3D4, 'h400, 'h000, 4'hF, 'hA1B2C3D4, excNone, 'h0, 1'b0, 'h0);

// loads from the word 8A7B_F6E5
addVector(opLb, 'h400, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'hFFFFFFE5);
addVector(opLb, 'h401, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'hFFFFFFF6);
addVector(opLb, 'h402, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h0000007B);
addVector(opLb, 'h403, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'hFFFFFF8A);
addVector(opLbu, 'h400, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h000000E5);
addVector(opLbu, 'h401, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h000000F6);
addVector(opLbu, 'h402, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h0000007B);
addVector(opLbu, 'h403, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h0000008A);
addVector(opLh, 'h400, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'hFFFFF6E5);
addVector(opLh, 'h402, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'hFFFF8A7B);
addVector(opLhu, 'h400, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h0000F6E5);
addVector(opLhu, 'h402, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h00008A7B);
addVector(opLw, 'h404, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h8A7BF6E5);

// misaligned data addresses, BadVAddr read back
addVector(opLw, 'h502, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excAdel, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h008, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h502);
addVector(opLh, 'h601, 'h8A7BF6E5, 'h400, 'h000, 4'h0, 'h0, excAdel, 'h0, 1'b0, 'h0);
addVector(opSw, 'h702, 'hA1B2C3D4, 'h400, 'h000, 4'h0, 'h0, excAdes, 'h0, 1'b0, 'h0);
addVector(opSh, 'h803, 'hA1B2C3D4, 'h400, 'h000, 4'h0, 'h0, excAdes, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h008, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h803);

// several flags at once, highest rank wins
addVector(opAlu, 'h000, 'h0, 'h900, 'h036, 4'h0, 'h0, excSys, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h000, 'h0, 'h904, 'h014, 4'h0, 'h0, excBp, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h000, 'h0, 'h908, 'h006, 4'h0, 'h0, excRi, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h000, 'h0, 'h90C, 'h00A, 4'h0, 'h0, excOv, 'h0, 1'b0, 'h0);
addVector(opSw, 'hA01, 'h0, 'h910, 'h020, 4'h0, 'h0, excAdes, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h000, 'h0, 'h402, 'h020, 4'h0, 'h0, excAdel, 'h0, 1'b0, 'h0);  // bad pc
addVector(opAlu, 'h008, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h402);
addVector(opAlu, 'h000, 'h0, 'hA04, 'h021, 4'h0, 'h0, excSys, 'h0, 1'b0, 'h0);  // delay slot
addVector(opAlu, 'h00E, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'hA00);
addVector(opAlu, 'h00D, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h80000020);

// IE plus IM for extInt[0], then interrupt and eret
addVector(opAlu, 'h00C, 'h401, 'h400, 'h040, 4'h0, 'h0, excNone, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h000, 'h0, 'hB00, 'h400, 4'h0, 'h0, excInt, 'h0, 1'b0, 'h0);
addVector(opAlu, 'h00C, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h403);
addVector(opAlu, 'h000, 'h0, 'hC00, 'h008, 4'h0, 'h0, excEret, 'hB00, 1'b0, 'h0);
addVector(opAlu, 'h00C, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h401);

// two stalled entries, wb and Status hold
addVector(opAlu, 'h00C, 'h0, 'h400, 'h140, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h401);
addVector(opLw, 'h404, 'h8A7BF6E5, 'h400, 'h100, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h401);
addVector(opAlu, 'h00C, 'h0, 'h400, 'h080, 4'h0, 'h0, excNone, 'h0, 1'b1, 'h401);

`endif

//--- testbench/memStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module memStageTb;
    import mipsMemPkg::*;

    localparam word_t   entryPc = 32'h8000_0180;
    localparam opcode_t opAlu   = 6'h00;  // any instruction without memory access

    typedef struct {
        opcode_t  op;
        word_t    addr;
        word_t    data;   // store data, read data or alu/mtc0 value
        word_t    pc;
        word_t    ctl;
        byteEn_t  be;
        word_t    wd;
        excCode_t exc;
        word_t    rdPc;   // eret target only
        logic     rw;
        word_t    wbd;
    } vector_t;

    logic     clk = 1'b0;
    logic     arstN;
    logic     stall;
    logic [5:0] extInt;
    memReq_t  req;
    word_t    readData;
    byteEn_t  byteEnable;
    word_t    writeData;
    logic     memEn;
    logic     isExc;
    excCode_t excCode;
    logic     redirectValid;
    word_t    redirectPc;
    wbData_t  wb;

    vector_t  tbl[$];
    int       errors = 0;
    int       startErrs = 0;
    int       cycles = 0;
    int       limit = 0;
    regAddr_t heldWreg;

    memStage #(.excEntry(entryPc)) i_dut (
        .clk(clk), .arstN(arstN), .stall(stall), .extInt(extInt), .req(req),
        .readData(readData), .byteEnable(byteEnable), .writeData(writeData),
        .memEn(memEn), .isExc(isExc), .excCode(excCode), .redirectValid(redirectValid),
        .redirectPc(redirectPc), .wb(wb)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: vector loop still running after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic isLoadOp(input opcode_t op);
        return (op == opLb) || (op == opLbu) || (op == opLh) || (op == opLhu) || (op == opLw);
    endfunction

    function automatic logic isStoreOp(input opcode_t op);
        return (op == opSb) || (op == opSh) || (op == opSw);
    endfunction

    task automatic addVector(input opcode_t op, input word_t addr, input word_t data,
                             input word_t pc, input word_t ctl, input byteEn_t be,
                             input word_t wd, input excCode_t exc, input word_t rdPc,
                             input logic rw, input word_t wbd);
        vector_t v;
        v = '{op, addr, data, pc, ctl, be, wd, exc, rdPc, rw, wbd};
        tbl.push_back(v);
    endtask

    task automatic buildTable();
        `include "memStageVectors.svh"
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkOutputs(input vector_t v, input logic memOp);
        checkValue("byteEnable", 32'(byteEnable), 32'(v.be));
        if (v.be != 0) begin
            checkValue("writeData", writeData, v.wd);  // lanes off, data is free
        end
        checkValue("excCode", 32'(excCode), 32'(v.exc));
        checkValue("isExc", 32'(isExc), 32'(v.exc != excNone));
        checkValue("memEn", 32'(memEn), 32'(memOp && v.exc == excNone));
        checkValue("redirectValid", 32'(redirectValid), 32'(v.exc != excNone));
        if (v.exc != excNone) begin
            checkValue("redirectPc", redirectPc, (v.exc == excEret) ? v.rdPc : entryPc);
        end
    endtask

    task automatic finishVector(input int idx);
        checkValue("wb.regWrite", 32'(wb.regWrite), 32'(tbl[idx].rw));
        if (tbl[idx].rw) begin
            checkValue("wb.wreg", 32'(wb.wreg), 32'(heldWreg));
            checkValue("wb.data", wb.data, tbl[idx].wbd);
        end
        $display("vector %0d %s", idx, (errors == startErrs) ? "ok" : "mismatch");
    endtask

    initial begin
        vector_t v;
        logic    ld;
        logic    st;
        void'($urandom(32'h3c41_17f3));
        arstN    = 1'b0;
        stall    = 1'b0;
        extInt   = '0;
        req      = '0;
        readData = '0;
        buildTable();
        limit = 4 * tbl.size() + 20;
        repeat (3) @(posedge clk);
        #1 arstN = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                finishVector(i - 1);  // wb of the entry before
            end
            v  = tbl[i];
            ld = isLoadOp(v.op);
            st = isStoreOp(v.op);
            startErrs = errors;
            if (!v.ctl[8]) begin
                heldWreg = regAddr_t'(i % 31 + 1);
            end
            req           = '0;
            req.valid     = 1'b1;
            req.op        = v.op;
            req.addr      = v.addr;
            req.storeData = st ? v.data : $urandom;
            req.pc        = v.pc;
            req.aluResult = v.data;
            req.wreg      = regAddr_t'(i % 31 + 1);
            req.regWrite  = ld | v.ctl[7];
            req.memToReg  = ld;
            req.mtc0      = v.ctl[6];
            req.mfc0      = v.ctl[7];
            req.cp0Addr   = v.addr[4:0];
            req.excFlags  = v.ctl[5:0];  // same bit order as excFlags_t
            readData      = ld ? v.data : $urandom;
            stall         = v.ctl[8];
            extInt        = v.ctl[15:10];
            #2;
            checkOutputs(v, ld | st);
        end
        @(posedge clk);
        #1;
        finishVector(tbl.size() - 1);
        $display("%0d vectors run, %0d errors", tbl.size(), errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
